/* dcache.f */
rtl/dcache_pkg.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_store_buffer.sv
rtl/dcache_miss_ctrl.sv
rtl/dcache.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

/* rtl/dcache.sv */
module dcache (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output logic                 rd_req,
    output dcache_pkg::addr_t    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  dcache_pkg::word_t    ret_data,
    output logic                 wr_req,
    output dcache_pkg::addr_t    wr_addr,
    output dcache_pkg::line_t    wr_data,
    input  logic                 wr_rdy,
    output logic                 cache_miss
);

    dcache_pkg::tagv_t    tagv0, tagv1;
    logic                 dirty0, dirty1;
    dcache_pkg::line_t    line0, line1;
    dcache_pkg::index_t   rd_index;
    logic                 tag_wr_en, tag_wr_way;
    dcache_pkg::index_t   tag_wr_index;
    dcache_pkg::tagv_t    tag_wr_tagv;
    logic                 dirty_set, dirty_way, fill_dirty;
    dcache_pkg::index_t   dirty_index;
    dcache_pkg::bank_wr_t store_push, store_wr, fill_wr;
    dcache_pkg::bank_t    busy_bank;
    logic                 busy;

    dcache_miss_ctrl ctrl_inst (
        .clk, .reset, .valid, .req,
        .tagv0, .tagv1, .dirty0, .dirty1, .line0, .line1,
        .busy, .busy_bank,
        .rd_rdy, .ret_valid, .ret_last, .ret_data, .wr_rdy,
        .addr_ok, .data_ok, .rdata, .rd_index,
        .tag_wr_en, .tag_wr_way, .tag_wr_index, .tag_wr_tagv,
        .dirty_set, .dirty_way, .dirty_index, .fill_dirty,
        .store_push, .fill_wr,
        .rd_req, .rd_addr, .wr_req, .wr_addr, .wr_data, .cache_miss
    );

    dcache_tag_array tag_inst (
        .clk, .reset, .rd_index,
        .wr_en       (tag_wr_en),
        .wr_way      (tag_wr_way),
        .wr_index    (tag_wr_index),
        .wr_tagv     (tag_wr_tagv),
        .dirty_set, .dirty_way, .dirty_index, .fill_dirty,
        .tagv0, .tagv1, .dirty0, .dirty1
    );

    // two writers share the banks, selected per bank inside
    dcache_data_array data_inst (
        .clk, .rd_index, .store_wr, .fill_wr,
        .line0, .line1
    );

    dcache_store_buffer sb_inst (
        .clk, .reset, .store_push,
        .store_wr, .busy_bank, .busy
    );

endmodule

/* rtl/dcache_data_array.sv */
module dcache_data_array (
    input  logic                 clk,
    input  dcache_pkg::index_t   rd_index,
    input  dcache_pkg::bank_wr_t store_wr,
    input  dcache_pkg::bank_wr_t fill_wr,
    output dcache_pkg::line_t    line0,
    output dcache_pkg::line_t    line1
);

    dcache_pkg::word_t rd_word [2][dcache_pkg::NUM_BANKS];

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < dcache_pkg::NUM_BANKS; b++) begin : g_bank
            dcache_pkg::word_t    mem [dcache_pkg::NUM_SETS];
            logic                 sel_store;
            logic                 sel_fill;
            logic                 wr_hit;
            dcache_pkg::bank_wr_t wr;
            dcache_pkg::index_t   addr;

            assign sel_store = store_wr.en && store_wr.way == 1'(w) &&
                               store_wr.bank == dcache_pkg::bank_t'(b);
            assign sel_fill  = fill_wr.en && fill_wr.way == 1'(w) &&
                               fill_wr.bank == dcache_pkg::bank_t'(b);
            assign wr_hit    = sel_store || sel_fill;

            // port select, the writer that names this bank owns it
            assign wr   = sel_store ? store_wr : fill_wr;
            assign addr = wr_hit ? wr.index : rd_index;

            always_ff @(posedge clk) begin
                if (wr_hit) begin
                    for (int i = 0; i < dcache_pkg::WORD_BITS / 8; i++) begin
                        if (wr.strb[i]) begin
                            mem[addr][i*8 +: 8] <= wr.data[i*8 +: 8];
                        end
                    end
                end
                rd_word[w][b] <= mem[addr];   // old data on a write cycle
            end
        end
    end

    assign line0 = {rd_word[0][3], rd_word[0][2], rd_word[0][1], rd_word[0][0]};
    assign line1 = {rd_word[1][3], rd_word[1][2], rd_word[1][1], rd_word[1][0]};

    // store buffer drains during lookup only, refill beats come much later
    a_no_port_collision: assert property (@(posedge clk)
        store_wr.en && fill_wr.en |->
            (store_wr.way != fill_wr.way) || (store_wr.bank != fill_wr.bank));

endmodule

/* rtl/dcache_miss_ctrl.sv */
module dcache_miss_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  dcache_pkg::cpu_req_t req,
    input  dcache_pkg::tagv_t    tagv0,
    input  dcache_pkg::tagv_t    tagv1,
    input  logic                 dirty0,
    input  logic                 dirty1,
    input  dcache_pkg::line_t    line0,
    input  dcache_pkg::line_t    line1,
    input  logic                 busy,
    input  dcache_pkg::bank_t    busy_bank,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  dcache_pkg::word_t    ret_data,
    input  logic                 wr_rdy,
    output logic                 addr_ok,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output dcache_pkg::index_t   rd_index,
    output logic                 tag_wr_en,
    output logic                 tag_wr_way,
    output dcache_pkg::index_t   tag_wr_index,
    output dcache_pkg::tagv_t    tag_wr_tagv,
    output logic                 dirty_set,
    output logic                 dirty_way,
    output dcache_pkg::index_t   dirty_index,
    output logic                 fill_dirty,
    output dcache_pkg::bank_wr_t store_push,
    output dcache_pkg::bank_wr_t fill_wr,
    output logic                 rd_req,
    output dcache_pkg::addr_t    rd_addr,
    output logic                 wr_req,
    output dcache_pkg::addr_t    wr_addr,
    output dcache_pkg::line_t    wr_data,
    output logic                 cache_miss
);

    dcache_pkg::main_state_t state;
    dcache_pkg::cpu_req_t    req_q;
    logic                    victim_q;
    dcache_pkg::bank_t       ret_cnt;
    logic                    wb_primed;
    dcache_pkg::line_t       wb_line;
    dcache_pkg::addr_t       wb_addr;
    logic [7:0]              lfsr;

    logic              is_idle, is_lookup, is_miss, is_replace, is_refill;
    logic              hit0, hit1, hit;
    dcache_pkg::bank_t req_bank, buf_bank;
    logic              sb_conflict, ld_after_st, accept;
    dcache_pkg::word_t hit_word, merged;
    logic              victim, victim_dirty;
    dcache_pkg::tag_t  victim_tag;
    dcache_pkg::line_t live_line;

    assign is_idle    = (state == dcache_pkg::MAIN_IDLE);
    assign is_lookup  = (state == dcache_pkg::MAIN_LOOKUP);
    assign is_miss    = (state == dcache_pkg::MAIN_MISS);
    assign is_replace = (state == dcache_pkg::MAIN_REPLACE);
    assign is_refill  = (state == dcache_pkg::MAIN_REFILL);

    // tag comes from the cpu port in the lookup cycle
    assign hit0 = tagv0.valid && (tagv0.tag == req.tag);
    assign hit1 = tagv1.valid && (tagv1.tag == req.tag);
    assign hit  = hit0 || hit1;

    assign req_bank    = req.offset[3:2];
    assign buf_bank    = req_q.offset[3:2];
    assign sb_conflict = busy && (busy_bank == req_bank);
    assign ld_after_st = req_q.op && !req.op && (buf_bank == req_bank);

    assign addr_ok  = (is_idle && !sb_conflict) ||
                      (is_lookup && hit && !sb_conflict && !ld_after_st);
    assign accept   = valid && addr_ok;
    assign rd_index = addr_ok ? req.index : req_q.index;

    assign hit_word = hit1 ? line1[buf_bank*dcache_pkg::WORD_BITS +: dcache_pkg::WORD_BITS]
                           : line0[buf_bank*dcache_pkg::WORD_BITS +: dcache_pkg::WORD_BITS];

    // invalid way first, else random
    assign victim       = !tagv0.valid ? 1'b0 : (!tagv1.valid ? 1'b1 : lfsr[7]);
    assign victim_dirty = victim ? (tagv1.valid && dirty1) : (tagv0.valid && dirty0);
    assign victim_tag   = victim ? tagv1.tag : tagv0.tag;
    assign live_line    = victim_q ? line1 : line0;

    always_comb begin
        for (int i = 0; i < dcache_pkg::WORD_BITS / 8; i++) begin
            merged[i*8 +: 8] = req_q.wstrb[i] ? req_q.wdata[i*8 +: 8] : ret_data[i*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= dcache_pkg::MAIN_IDLE;
            ret_cnt   <= '0;
            wb_primed <= 1'b0;
            lfsr      <= 8'd1;
        end else begin
            lfsr      <= {lfsr[6], lfsr[5:3] ^ {3{lfsr[7]}}, lfsr[2:0], lfsr[7]};
            wb_primed <= is_miss;   // banks re-read once before write-back
            case (state)
                dcache_pkg::MAIN_IDLE: begin
                    if (accept) begin
                        state <= dcache_pkg::MAIN_LOOKUP;
                    end
                end
                dcache_pkg::MAIN_LOOKUP: begin
                    if (hit) begin
                        state <= accept ? dcache_pkg::MAIN_LOOKUP : dcache_pkg::MAIN_IDLE;
                    end else begin
                        state <= victim_dirty ? dcache_pkg::MAIN_MISS
                                              : dcache_pkg::MAIN_REPLACE;
                    end
                end
                dcache_pkg::MAIN_MISS: begin
                    if (wr_req) begin
                        state <= dcache_pkg::MAIN_REPLACE;
                    end
                end
                dcache_pkg::MAIN_REPLACE: begin
                    ret_cnt <= '0;
                    if (rd_rdy) begin
                        state <= dcache_pkg::MAIN_REFILL;
                    end
                end
                dcache_pkg::MAIN_REFILL: begin
                    if (ret_valid) begin
                        ret_cnt <= ret_cnt + 2'd1;
                        if (ret_last) begin
                            state <= dcache_pkg::MAIN_IDLE;
                        end
                    end
                end
                default: begin
                    state <= dcache_pkg::MAIN_IDLE;
                end
            endcase
        end
    end

    // request buffer and write-back payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end else if (is_lookup) begin
            req_q.tag <= req.tag;
            victim_q  <= victim;
            wb_addr   <= {victim_tag, req_q.index, dcache_pkg::offset_t'(0)};
        end
        if (is_miss) begin
            wb_line <= live_line;
        end
    end

    assign data_ok = (is_lookup && (hit || req_q.op)) ||
                     (is_refill && ret_valid && !req_q.op && ret_cnt == buf_bank);
    assign rdata   = is_refill ? ret_data : hit_word;

    always_comb begin
        store_push.en    = is_lookup && hit && req_q.op;
        store_push.way   = hit1;
        store_push.index = req_q.index;
        store_push.bank  = buf_bank;
        store_push.strb  = req_q.wstrb;
        store_push.data  = req_q.wdata;

        fill_wr.en    = is_refill && ret_valid;
        fill_wr.way   = victim_q;
        fill_wr.index = req_q.index;
        fill_wr.bank  = ret_cnt;
        fill_wr.strb  = '1;
        fill_wr.data  = (req_q.op && ret_cnt == buf_bank) ? merged : ret_data;

        tag_wr_tagv.tag   = req_q.tag;
        tag_wr_tagv.valid = 1'b1;
    end

    assign tag_wr_en    = is_refill && ret_valid && ret_last;
    assign tag_wr_way   = victim_q;
    assign tag_wr_index = req_q.index;
    assign fill_dirty   = req_q.op;

    assign dirty_set   = store_push.en;
    assign dirty_way   = hit1;
    assign dirty_index = req_q.index;

    assign rd_req  = is_replace;
    assign rd_addr = {req_q.tag, req_q.index, dcache_pkg::offset_t'(0)};
    assign wr_req  = is_miss && wb_primed && wr_rdy;
    assign wr_addr = wb_addr;
    assign wr_data = is_miss ? live_line : wb_line;   // held after the handshake

    assign cache_miss = is_refill && ret_valid && ret_last;

    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(rd_req && wr_req));

    a_data_ok_state: assert property (@(posedge clk) disable iff (reset)
        data_ok |-> (is_lookup || is_refill));

endmodule

/* rtl/dcache_pkg.sv */
package dcache_pkg;

    localparam int NUM_SETS    = 256;
    localparam int NUM_BANKS   = 4;
    localparam int WORD_BITS   = 32;
    localparam int TAG_BITS    = 20;
    localparam int INDEX_BITS  = 8;
    localparam int OFFSET_BITS = 4;

    typedef logic [TAG_BITS-1:0]              tag_t;
    typedef logic [INDEX_BITS-1:0]            index_t;
    typedef logic [OFFSET_BITS-1:0]           offset_t;
    typedef logic [OFFSET_BITS-3:0]           bank_t;   // word within the line
    typedef logic [WORD_BITS-1:0]             word_t;
    typedef logic [WORD_BITS/8-1:0]           strb_t;
    typedef logic [NUM_BANKS*WORD_BITS-1:0]   line_t;
    typedef logic [TAG_BITS+INDEX_BITS+OFFSET_BITS-1:0] addr_t;

    // one-hot main controller states
    typedef enum logic [4:0] {
        MAIN_IDLE    = 5'b00001,
        MAIN_LOOKUP  = 5'b00010,
        MAIN_MISS    = 5'b00100,
        MAIN_REPLACE = 5'b01000,
        MAIN_REFILL  = 5'b10000
    } main_state_t;

    typedef enum logic [0:0] {
        STORE_IDLE = 1'b0,
        STORE_FULL = 1'b1
    } store_state_t;

    typedef struct packed {
        logic    op;       // 1 = store
        index_t  index;
        tag_t    tag;      // arrives one cycle late
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    // a single write into one bank of one way
    typedef struct packed {
        logic   en;
        logic   way;
        index_t index;
        bank_t  bank;
        strb_t  strb;
        word_t  data;
    } bank_wr_t;

endpackage

/* rtl/dcache_store_buffer.sv */
module dcache_store_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  dcache_pkg::bank_wr_t store_push,
    output dcache_pkg::bank_wr_t store_wr,
    output dcache_pkg::bank_t    busy_bank,
    output logic                 busy
);

    dcache_pkg::store_state_t state;
    dcache_pkg::bank_wr_t     held;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dcache_pkg::STORE_IDLE;
        end else begin
            case (state)
                dcache_pkg::STORE_IDLE: begin
                    if (store_push.en) begin
                        state <= dcache_pkg::STORE_FULL;
                    end
                end
                dcache_pkg::STORE_FULL: begin
                    // stays full while hit stores keep coming
                    if (!store_push.en) begin
                        state <= dcache_pkg::STORE_IDLE;
                    end
                end
                default: begin
                    state <= dcache_pkg::STORE_IDLE;
                end
            endcase
        end
    end

    // held store, no reset
    always_ff @(posedge clk) begin
        if (store_push.en) begin
            held <= store_push;
        end
    end

    always_comb begin
        store_wr    = held;
        store_wr.en = (state == dcache_pkg::STORE_FULL);
    end

    assign busy      = (state == dcache_pkg::STORE_FULL);
    assign busy_bank = held.bank;   // bank a new load must not read

endmodule

/* rtl/dcache_tag_array.sv */
module dcache_tag_array (
    input  logic                clk,
    input  logic                reset,
    input  dcache_pkg::index_t  rd_index,
    input  logic                wr_en,
    input  logic                wr_way,
    input  dcache_pkg::index_t  wr_index,
    input  dcache_pkg::tagv_t   wr_tagv,
    input  logic                dirty_set,
    input  logic                dirty_way,
    input  dcache_pkg::index_t  dirty_index,
    input  logic                fill_dirty,
    output dcache_pkg::tagv_t   tagv0,
    output dcache_pkg::tagv_t   tagv1,
    output logic                dirty0,
    output logic                dirty1
);

    dcache_pkg::tag_t              tag_mem [2][dcache_pkg::NUM_SETS];
    logic [dcache_pkg::NUM_SETS-1:0] valid_q [2];
    logic [dcache_pkg::NUM_SETS-1:0] dirty_q [2];

    dcache_pkg::tag_t tag_rd   [2];
    logic             valid_rd [2];
    logic             dirty_rd [2];

    // tag payload, no reset
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][wr_index] <= wr_tagv.tag;
        end
        for (int w = 0; w < 2; w++) begin
            tag_rd[w] <= tag_mem[w][rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < 2; w++) begin
                valid_q[w]  <= '0;
                dirty_q[w]  <= '0;
                valid_rd[w] <= 1'b0;
                dirty_rd[w] <= 1'b0;
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                valid_rd[w] <= valid_q[w][rd_index];
                // a hit store in the same cycle must show up for the next lookup
                dirty_rd[w] <= dirty_q[w][rd_index] |
                               (dirty_set && dirty_way == 1'(w) && dirty_index == rd_index);
                if (wr_en && wr_way == 1'(w)) begin
                    valid_q[w][wr_index] <= wr_tagv.valid;
                    dirty_q[w][wr_index] <= fill_dirty;   // refill of a store miss is dirty
                end else if (dirty_set && dirty_way == 1'(w)) begin
                    dirty_q[w][dirty_index] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        tagv0.tag   = tag_rd[0];
        tagv0.valid = valid_rd[0];
        tagv1.tag   = tag_rd[1];
        tagv1.valid = valid_rd[1];
    end

    assign dirty0 = dirty_rd[0];
    assign dirty1 = dirty_rd[1];

endmodule

/* run.sh */
#!/bin/bash
# build the dcache testbench with Verilator, run it, then look for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
    -f dcache.f -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx '>>> PASS' sim.log && echo "run passed" || { echo "run failed"; exit 1; }

/* test/dcache_mem_model.sv */
module dcache_mem_model (
    input  logic               clk,
    input  logic               reset,
    input  logic               hold,      // random stall from the testbench
    input  logic               rd_req,
    input  dcache_pkg::addr_t  rd_addr,
    output logic               rd_rdy,
    output logic               ret_valid,
    output logic               ret_last,
    output dcache_pkg::word_t  ret_data,
    input  logic               wr_req,
    input  dcache_pkg::addr_t  wr_addr,
    input  dcache_pkg::line_t  wr_data,
    output logic               wr_rdy
);

    dcache_pkg::word_t mem [dcache_pkg::addr_t];   // only words that were written back
    dcache_pkg::line_t line_buf  = '0;
    dcache_pkg::bank_t beat      = '0;
    logic              refilling = 1'b0;

    // untouched words follow the address rule
    function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    assign rd_rdy    = !reset && rd_req && !refilling && !hold;
    assign ret_valid = !reset && refilling && !hold;   // gaps while hold is high
    assign ret_last  = ret_valid && beat == 2'd3;
    assign ret_data  = line_buf[beat*32 +: 32];
    assign wr_rdy    = !reset && !hold;

    always @(posedge clk) begin
        if (reset) begin
            refilling <= 1'b0;
            beat      <= '0;
        end else begin
            if (rd_req && rd_rdy) begin
                refilling <= 1'b1;
                beat      <= '0;
                for (int b = 0; b < 4; b++) begin
                    line_buf[b*32 +: 32] <= read_word({rd_addr[31:4], 2'(b), 2'b00});
                end
            end else if (ret_valid) begin
                beat <= beat + 2'd1;
                if (beat == 2'd3) begin
                    refilling <= 1'b0;
                end
            end
            if (wr_req) begin
                for (int b = 0; b < 4; b++) begin
                    mem[{wr_addr[31:4], 2'(b), 2'b00}] = wr_data[b*32 +: 32];
                end
            end
        end
    end

endmodule

/* test/dcache_tb.sv */
module dcache_tb;

    localparam int NUM_RAND   = 400;
    localparam int NUM_REQ    = NUM_RAND + 6;
    localparam int MAX_CYCLES = 40 * NUM_REQ + 200;

    logic                 clk, reset, valid, hold;
    dcache_pkg::cpu_req_t req;
    logic                 addr_ok, data_ok, rd_req, rd_rdy, ret_valid, ret_last;
    logic                 wr_req, wr_rdy, cache_miss;
    dcache_pkg::word_t    rdata, ret_data;
    dcache_pkg::addr_t    rd_addr, wr_addr;
    dcache_pkg::line_t    wr_data;

    logic [31:0]          lfsr;
    logic                 took;        // request taken at the last rising edge
    dcache_pkg::addr_t    cur_addr;
    logic                 cur_known;   // last line touched in its set, so resident
    dcache_pkg::word_t    shadow [dcache_pkg::addr_t];
    logic                 dirty_line [logic [27:0]];
    dcache_pkg::tag_t     last_tag [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::NUM_SETS-1:0] touched;
    logic                 exp_load [NUM_REQ];
    dcache_pkg::word_t    exp_word [NUM_REQ];
    int                   wr_ptr, rd_ptr, cycles;
    dcache_pkg::line_t    wb_expect;
    logic                 wb_dirty;
    dcache_pkg::addr_t    acc_addr;    // last accepted request, the one a refill serves
    logic                 miss_owed;   // refill under way, its cache_miss still to come

    dcache dcache_inst (.*);

    dcache_mem_model mem_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic dcache_pkg::word_t shadow_word(input dcache_pkg::addr_t a);
        dcache_pkg::addr_t w;
        w = {a[31:2], 2'b00};
        if (shadow.exists(w)) begin
            return shadow[w];
        end
        return w ^ 32'h5a5a0000;   // memory rule
    endfunction

    function automatic dcache_pkg::line_t shadow_line(input dcache_pkg::addr_t a);
        dcache_pkg::line_t l;
        for (int b = 0; b < 4; b++) begin
            l[b*32 +: 32] = shadow_word({a[31:4], 2'(b), 2'b00});
        end
        return l;
    endfunction

    function automatic void merge_store(input dcache_pkg::addr_t a, input dcache_pkg::strb_t s,
                                        input dcache_pkg::word_t d);
        dcache_pkg::word_t w;
        w = shadow_word(a);
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                w[i*8 +: 8] = d[i*8 +: 8];
            end
        end
        shadow[{a[31:2], 2'b00}] = w;
    endfunction

    // one falling edge, memory stall flips now and then
    task automatic next_cycle();
        @(negedge clk);
        if (rand_bits(2) == 0) begin
            hold = !hold;
        end
    endtask

    task automatic send_req(input logic op, input dcache_pkg::addr_t addr,
                            input dcache_pkg::strb_t strb, input dcache_pkg::word_t data);
        req.op     = op;
        req.index  = addr[11:4];
        req.offset = addr[3:0];
        req.wstrb  = strb;
        req.wdata  = data;
        if (!took) begin
            req.tag = addr[31:12];   // otherwise the previous tag is still in lookup
        end
        cur_addr  = addr;
        cur_known = touched[addr[11:4]] && last_tag[addr[11:4]] == addr[31:12];
        valid     = 1'b1;
        do begin
            next_cycle();
            if (!took) begin
                req.tag = addr[31:12];
            end
        end while (!took);
        req.tag = addr[31:12];       // late tag for the lookup cycle
        valid   = 1'b0;
    endtask

    // acceptance log, shadow update and pointers
    always @(posedge clk) begin
        if (reset) begin
            took      <= 1'b0;
            wr_ptr    <= 0;
            rd_ptr    <= 0;
            touched   <= '0;
            miss_owed <= 1'b0;
        end else begin
            took <= valid && addr_ok;
            if (valid && addr_ok) begin
                exp_load[wr_ptr] <= !req.op;
                exp_word[wr_ptr] <= shadow_word(cur_addr);
                if (req.op) begin
                    merge_store(cur_addr, req.wstrb, req.wdata);
                    dirty_line[cur_addr[31:4]] = 1'b1;
                end
                touched[cur_addr[11:4]]  <= 1'b1;
                last_tag[cur_addr[11:4]] <= cur_addr[31:12];
                acc_addr <= cur_addr;
                wr_ptr <= wr_ptr + 1;
            end
            if (data_ok) begin
                rd_ptr <= rd_ptr + 1;
            end
            if (wr_req) begin
                dirty_line.delete(wr_addr[31:4]);
            end
            if (rd_req && rd_rdy) begin
                miss_owed <= 1'b1;
            end else if (cache_miss) begin
                miss_owed <= 1'b0;
            end
        end
    end

    // write-back expectation settles at the falling edge
    always @(negedge clk) begin
        wb_expect <= shadow_line(wr_addr);
        wb_dirty  <= dirty_line.exists(wr_addr[31:4]);
    end

    always @(posedge clk) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
            if (cycles > MAX_CYCLES) begin
                fail_run("timeout, the cache stopped answering requests");
            end
        end
    end

    a_load_data: assert property (@(posedge clk) disable iff (reset)
        data_ok && exp_load[rd_ptr] |-> rdata == exp_word[rd_ptr])
        else fail_run($sformatf("MISMATCH time %0t rdata got %h expected %h",
                                $time, $sampled(rdata), $sampled(exp_word[rd_ptr])));

    a_data_ok_owed: assert property (@(posedge clk) disable iff (reset)
        data_ok |-> rd_ptr != wr_ptr)
        else fail_run("data_ok came with no request outstanding");

    a_hit_latency: assert property (@(posedge clk) disable iff (reset)
        valid && addr_ok && cur_known |=> data_ok)
        else fail_run("no data_ok one cycle after a request to a resident line");

    a_miss_pulse: assert property (@(posedge clk) disable iff (reset)
        cache_miss |-> miss_owed)
        else fail_run("cache_miss pulsed outside a refill or twice in one refill");

    a_miss_seen: assert property (@(posedge clk) disable iff (reset)
        (rd_req && rd_rdy) || addr_ok |-> !miss_owed)
        else fail_run("a refill ended without its cache_miss pulse");

    a_rd_line: assert property (@(posedge clk) disable iff (reset)
        rd_req |-> rd_addr == (acc_addr & 32'hffff_fff0))
        else fail_run($sformatf("MISMATCH time %0t rd_addr got %h expected %h",
                                $time, $sampled(rd_addr),
                                $sampled(acc_addr) & 32'hffff_fff0));

    a_wb_line: assert property (@(posedge clk) disable iff (reset)
        wr_req |-> wb_dirty && wr_data == wb_expect)
        else fail_run($sformatf("MISMATCH time %0t wr_data got %h expected %h dirty %b",
                                $time, $sampled(wr_data), $sampled(wb_expect),
                                $sampled(wb_dirty)));

    a_mem_stall: assert property (@(posedge clk) disable iff (reset)
        rd_req || wr_req || (miss_owed && !ret_valid) |-> !addr_ok && !data_ok)
        else fail_run("CPU handshake while a memory request was pending");

    a_rd_hold: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req)
        else fail_run("rd_req dropped before rd_rdy");

    a_wb_then_rd: assert property (@(posedge clk) disable iff (reset)
        wr_req |=> rd_req)
        else fail_run("no refill read after a write-back");

    initial begin
        dcache_pkg::addr_t addr;
        dcache_pkg::tag_t  tag;
        dcache_pkg::index_t idx;
        logic [1:0]        sel;
        lfsr  = 32'h6a00;
        hold  = 1'b0;
        valid = 1'b0;
        req   = '0;
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // cold line, then the same line again
        send_req(1'b0, 32'h0001_2044, 4'h0, '0);
        send_req(1'b0, 32'h0001_2048, 4'h0, '0);
        // store hit with a load of the same bank right behind it
        send_req(1'b1, 32'h0001_2044, 4'b0101, 32'hdead_beef);
        send_req(1'b0, 32'h0001_2044, 4'h0, '0);
        // store miss allocates
        send_req(1'b1, 32'h0003_4088, 4'b1100, 32'hcafe_f00d);
        send_req(1'b0, 32'h0003_4088, 4'h0, '0);

        // four sets, three lines each, so evictions are frequent
        for (int n = 0; n < NUM_RAND; n++) begin
            idx  = 8'h20 + 8'(rand_bits(2));
            sel  = 2'(rand_bits(2));
            tag  = 20'h00100 + 20'(sel == 2'd3 ? 2'd0 : sel);
            addr = {tag, idx, 2'(rand_bits(2)), 2'b00};
            send_req(1'(rand_bits(1)), addr, 4'(rand_bits(4)), rand_bits(32));
            if (rand_bits(2) == 0) begin
                next_cycle();
            end
        end

        // last refill of a store miss may still be running
        while (rd_ptr != wr_ptr || !addr_ok) begin
            next_cycle();
        end
        repeat (8) next_cycle();
        if (wr_ptr == NUM_REQ && rd_ptr == wr_ptr) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_run("count of data_ok pulses differs from accepted requests");
        end
    end

endmodule
